// File: vlog.f
hdl/cpu_pkg.sv
hdl/reg_slice.sv
hdl/operand_select.sv
hdl/execute_unit.sv
hdl/instr_sequencer.sv
hdl/cpu_top.sv
verification/cpu_props.sv
verification/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the cpu_top testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module cpu_tb -o cpu_sim

./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: verification/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
    import cpu_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    // upper bound of instructions over all programs, including the reset loop.
    localparam int TOTAL_INSTR = 120;
    localparam int WATCHDOG_NS = TOTAL_INSTR * 3 * CLK_PERIOD * 4;

    logic  clock;
    logic  arst_n;
    word_t mem_rdata;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_read;
    logic  mem_write;
    logic  halted;

    word_t mem [256];
    word_t prog [$];
    word_t cap_addr [$];
    word_t cap_data [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    errors;
    int    tests_passed;
    int    tests_failed;
    int    seed;

    cpu_top DUT (
        .clock     (clock),
        .arst_n    (arst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .halted    (halted)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // memory answers one cycle after the read strobe and logs every store.
    always @(posedge clock)
    begin
        if (mem_read)
            mem_rdata <= mem[mem_addr[7:0]];
        if (mem_write)
        begin
            cap_addr.push_back(mem_addr);
            cap_data.push_back(mem_wdata);
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic word_t encode(opcode_t op, reg_sel_t d, reg_sel_t a, reg_sel_t b,
                                     imm_t imm);
        return {imm, b, a, d, op};
    endfunction

    task automatic emit(opcode_t op, reg_sel_t d, reg_sel_t a, reg_sel_t b, imm_t imm);
        prog.push_back(encode(op, d, a, b, imm));
    endtask

    // full word needs load low then load high with source a as the destination.
    task automatic load_const(reg_sel_t r, word_t v);
        emit(OP_LDL, r, 3'd0, 3'd0, v[15:0]);
        emit(OP_LDH, r, r, 3'd0, v[31:16]);
    endtask

    // branch on the flag of r over the next instruction.
    task automatic branch_skip(reg_sel_t r);
        emit(OP_BRANCH, 3'd0, r, 3'd0, imm_t'(prog.size() + 2));
    endtask

    task automatic expect_store(word_t addr, word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic compare_word(string name, word_t expected, word_t actual);
        if (expected !== actual)
        begin
            $display("error %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_bit(string name, logic expected, logic actual);
        if (expected !== actual)
        begin
            $display("error %s expected %b actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic new_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic apply_reset(string name);
        @(posedge clock);
        arst_n <= 1'b0;
        for (int i = 0; i < 3; i++)
        begin
            @(negedge clock);
            compare_bit({name, " reset mem_read"}, 1'b0, mem_read);
            compare_bit({name, " reset mem_write"}, 1'b0, mem_write);
            compare_bit({name, " reset halted"}, 1'b0, halted);
        end
        foreach (mem[i])
            mem[i] = '0;
        foreach (prog[i])
            mem[i] = prog[i];
        cap_addr.delete();
        cap_data.delete();
        @(posedge clock);
        arst_n <= 1'b1;
    endtask

    // counts rising edges after the release edge until halted shows.
    task automatic run_program(string name, output int cycles);
        int limit;
        limit = prog.size() * 3 + 10;
        apply_reset(name);
        cycles = 0;
        while (cycles < limit)
        begin
            @(posedge clock);
            cycles++;
            @(negedge clock);
            if (halted)
                break;
        end
        if (!halted)
        begin
            $display("%s: halted never rose within %0d cycles", name, limit);
            errors++;
        end
    endtask

    task automatic check_stores(string name);
        compare_word({name, " store count"}, word_t'(exp_data.size()),
                     word_t'(cap_data.size()));
        foreach (exp_data[i])
        begin
            if (i < cap_data.size())
            begin
                compare_word($sformatf("%s store %0d addr", name, i), exp_addr[i], cap_addr[i]);
                compare_word($sformatf("%s store %0d data", name, i), exp_data[i], cap_data[i]);
            end
        end
    endtask

    task automatic report_test(string name, int start_errors);
        if (errors == start_errors)
        begin
            $display("test %s passed", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s failed", name);
            tests_failed++;
        end
    endtask

    task automatic test_arith(string name, word_t x, word_t y);
        int    start;
        int    cycles;
        word_t sum;
        word_t diff;
        start = errors;
        new_program();
        load_const(3'd1, x);
        load_const(3'd2, y);
        emit(OP_LDL, 3'd7, 3'd0, 3'd0, 16'h0080);
        emit(OP_LDL, 3'd5, 3'd0, 3'd0, 16'h00ca);
        emit(OP_LDL, 3'd6, 3'd0, 3'd0, 16'h00b0);
        emit(OP_ADD, 3'd3, 3'd1, 3'd2, 16'h0);
        emit(OP_SUB, 3'd4, 3'd1, 3'd2, 16'h0);
        emit(OP_STORE, 3'd0, 3'd3, 3'd0, 16'h0);
        emit(OP_STORE, 3'd0, 3'd4, 3'd0, 16'h0);
        branch_skip(3'd3);
        emit(OP_STORE, 3'd0, 3'd5, 3'd0, 16'h0);
        branch_skip(3'd4);
        emit(OP_STORE, 3'd0, 3'd6, 3'd0, 16'h0);
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0);
        sum = x + y;
        diff = x - y;
        expect_store(32'h80, sum);
        expect_store(32'h80, diff);
        // a marker is stored only when its flag is clear.
        // the wrapped sum drops below x exactly on a carry out.
        if (sum >= x)
            expect_store(32'h80, 32'h00ca);
        if (y <= x)
            expect_store(32'h80, 32'h00b0);
        run_program(name, cycles);
        check_stores(name);
        report_test(name, start);
    endtask

    task automatic test_logic();
        string    name;
        int       start;
        int       cycles;
        word_t    a;
        word_t    b;
        opcode_t  ops [3];
        word_t    res [3];
        name = "logic";
        start = errors;
        a = 32'hf0f0_1234;
        b = 32'h0ff0_4321;
        ops[0] = OP_AND;
        ops[1] = OP_OR;
        ops[2] = OP_XOR;
        res[0] = 32'h00f0_0220;
        res[1] = 32'hfff0_5335;
        res[2] = 32'hff00_5115;
        new_program();
        load_const(3'd1, a);
        load_const(3'd2, b);
        emit(OP_LDL, 3'd7, 3'd0, 3'd0, 16'h0084);
        for (int i = 0; i < 3; i++)
        begin
            // compare sets the flag first so the logic op must clear it.
            emit(OP_CMP, reg_sel_t'(3 + i), 3'd0, 3'd1, 16'h0);
            emit(ops[i], reg_sel_t'(3 + i), 3'd1, 3'd2, 16'h0);
            branch_skip(reg_sel_t'(3 + i));
            emit(OP_STORE, 3'd0, reg_sel_t'(3 + i), 3'd0, 16'h0);
            expect_store(32'h84, res[i]);
        end
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0);
        run_program(name, cycles);
        check_stores(name);
        report_test(name, start);
    endtask

    task automatic test_load_high();
        string name;
        int    start;
        int    cycles;
        name = "load_high";
        start = errors;
        new_program();
        emit(OP_LDL, 3'd7, 3'd0, 3'd0, 16'h0088);
        emit(OP_LDL, 3'd1, 3'd0, 3'd0, 16'h1234);
        emit(OP_STORE, 3'd0, 3'd1, 3'd0, 16'h0);
        emit(OP_LDH, 3'd1, 3'd1, 3'd0, 16'habcd);
        emit(OP_STORE, 3'd0, 3'd1, 3'd0, 16'h0);
        emit(OP_LDL, 3'd1, 3'd0, 3'd0, 16'h5678);
        emit(OP_STORE, 3'd0, 3'd1, 3'd0, 16'h0);
        emit(OP_LDH, 3'd1, 3'd1, 3'd0, 16'h0009);
        emit(OP_STORE, 3'd0, 3'd1, 3'd0, 16'h0);
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0);
        expect_store(32'h88, 32'h0000_1234);
        expect_store(32'h88, 32'habcd_1234);
        expect_store(32'h88, 32'h0000_5678);
        expect_store(32'h88, 32'h0009_5678);
        run_program(name, cycles);
        check_stores(name);
        report_test(name, start);
    endtask

    task automatic test_compare_branch();
        string name;
        int    start;
        int    cycles;
        name = "compare_branch";
        start = errors;
        new_program();
        emit(OP_LDL, 3'd7, 3'd0, 3'd0, 16'h008c);
        emit(OP_LDL, 3'd1, 3'd0, 3'd0, 16'd5);
        emit(OP_LDL, 3'd2, 3'd0, 3'd0, 16'd9);
        emit(OP_LDL, 3'd3, 3'd0, 3'd0, 16'h0077);
        emit(OP_CMP, 3'd3, 3'd1, 3'd2, 16'h0);
        branch_skip(3'd3);
        emit(OP_STORE, 3'd0, 3'd1, 3'd0, 16'h0);
        emit(OP_STORE, 3'd0, 3'd2, 3'd0, 16'h0);
        emit(OP_CMP, 3'd4, 3'd2, 3'd1, 16'h0);
        branch_skip(3'd4);
        emit(OP_STORE, 3'd0, 3'd1, 3'd0, 16'h0);
        emit(OP_STORE, 3'd0, 3'd3, 3'd0, 16'h0);
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0);
        expect_store(32'h8c, 32'd9);
        expect_store(32'h8c, 32'd5);
        expect_store(32'h8c, 32'h77);
        run_program(name, cycles);
        check_stores(name);
        report_test(name, start);
    endtask

    task automatic test_store_timing();
        string name;
        int    start;
        int    cycles;
        name = "store_timing";
        start = errors;
        new_program();
        emit(OP_LDL, 3'd7, 3'd0, 3'd0, 16'h0090);
        emit(OP_LDL, 3'd1, 3'd0, 3'd0, 16'h0011);
        emit(OP_STORE, 3'd0, 3'd1, 3'd0, 16'h0);
        emit(OP_LDL, 3'd7, 3'd0, 3'd0, 16'h0091);
        emit(OP_STORE, 3'd0, 3'd1, 3'd0, 16'h0);
        emit(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0);
        expect_store(32'h90, 32'h11);
        expect_store(32'h91, 32'h11);
        run_program(name, cycles);
        check_stores(name);
        // three cycles per instruction from the release edge.
        compare_word({name, " halt cycles"}, word_t'(3 * prog.size()), word_t'(cycles));
        compare_bit({name, " halted level"}, 1'b1, halted);
        report_test(name, start);
    endtask

    task automatic test_reset();
        string name;
        int    start;
        int    wait_cycles;
        name = "reset";
        start = errors;
        new_program();
        emit(OP_STORE, 3'd0, 3'd1, 3'd0, 16'h0);
        emit(OP_LDL, 3'd1, 3'd0, 3'd0, 16'h0055);
        emit(OP_LDL, 3'd7, 3'd0, 3'd0, 16'h00a0);
        emit(OP_CMP, 3'd2, 3'd0, 3'd1, 16'h0);
        emit(OP_BRANCH, 3'd0, 3'd2, 3'd0, 16'd4);
        expect_store(32'h0, 32'h0);
        apply_reset(name);
        repeat (30) @(posedge clock);
        apply_reset(name);
        @(negedge clock);
        compare_bit({name, " first fetch"}, 1'b1, mem_read);
        compare_word({name, " first fetch addr"}, 32'h0, mem_addr);
        wait_cycles = 0;
        while (cap_data.size() == 0 && wait_cycles < 10)
        begin
            @(negedge clock);
            wait_cycles++;
        end
        check_stores(name);
        compare_bit({name, " halted"}, 1'b0, halted);
        report_test(name, start);
    endtask

    initial
    begin
        word_t x;
        word_t y;
        clock = 1'b0;
        arst_n = 1'b0;
        mem_rdata = '0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        seed = 17;
        foreach (mem[i])
            mem[i] = '0;

        x = $random(seed);
        y = $random(seed);
        test_arith("arith_random", x, y);
        test_arith("arith_carry", 32'hffff_fff0, 32'h0000_0020);
        test_arith("arith_borrow", 32'h0000_0005, 32'h0000_0009);
        test_logic();
        test_load_high();
        test_compare_branch();
        test_store_timing();
        test_reset();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: verification/cpu_props.sv
`timescale 1ns/1ps

module cpu_props
(
    input logic clock,
    input logic arst_n,
    input logic mem_read,
    input logic mem_write,
    input logic halted
);

    a_no_read_write: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(mem_read && mem_write)
    ) else $error("mem_read and mem_write are high together");

    // a halted core stays off the bus.
    a_quiet_halt: assert property (
        @(posedge clock) disable iff (!arst_n)
        halted |-> !(mem_read || mem_write)
    ) else $error("bus strobe while halted");

    a_write_after_read: assert property (
        @(posedge clock) disable iff (!arst_n)
        mem_write |-> $past(mem_read, 2)
    ) else $error("mem_write not two cycles after mem_read");

endmodule

bind cpu_top cpu_props u_props (
    .clock     (clock),
    .arst_n    (arst_n),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .halted    (halted)
);

// File: hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic  clock,
    input  logic  arst_n,
    input  word_t mem_rdata,
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_read,
    output logic  mem_write,
    output logic  halted
);

    opcode_t              opcode;
    reg_sel_t             dst_sel;
    reg_sel_t             src_a_sel;
    reg_sel_t             src_b_sel;
    imm_t                 imm;
    logic                 exec;
    word_t                operand_a;
    word_t                operand_b;
    word_t                store_addr;
    logic                 flag_a;
    logic                 wr_en;
    logic                 wr_word_en;
    logic                 wr_flag;
    reg_sel_t             wr_sel;
    word_t                wr_word;
    logic                 branch_taken;
    word_t                branch_target;
    word_t                slice_words [NUM_REGS];
    logic  [NUM_REGS-1:0] slice_flags;

    instr_sequencer u_sequencer (
        .clock         (clock),
        .arst_n        (arst_n),
        .mem_rdata     (mem_rdata),
        .operand_a     (operand_a),
        .store_addr    (store_addr),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .opcode        (opcode),
        .dst_sel       (dst_sel),
        .src_a_sel     (src_a_sel),
        .src_b_sel     (src_b_sel),
        .imm           (imm),
        .exec          (exec),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .halted        (halted)
    );

    execute_unit u_execute (
        .exec          (exec),
        .opcode        (opcode),
        .dst_sel       (dst_sel),
        .imm           (imm),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .flag_a        (flag_a),
        .wr_en         (wr_en),
        .wr_word_en    (wr_word_en),
        .wr_flag       (wr_flag),
        .wr_sel        (wr_sel),
        .wr_word       (wr_word),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    // one slice per general register a to h.
    genvar gi;
    generate
        for (gi = 0; gi < NUM_REGS; gi++)
        begin : g_slice
            reg_slice #(
                .slice_index (gi)
            ) u_slice (
                .clock      (clock),
                .arst_n     (arst_n),
                .wr_en      (wr_en),
                .wr_word_en (wr_word_en),
                .wr_flag    (wr_flag),
                .wr_sel     (wr_sel),
                .wr_word    (wr_word),
                .word       (slice_words[gi]),
                .flag       (slice_flags[gi])
            );
        end
    endgenerate

    operand_select u_select (
        .slice_words (slice_words),
        .slice_flags (slice_flags),
        .src_a_sel   (src_a_sel),
        .src_b_sel   (src_b_sel),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .store_addr  (store_addr),
        .flag_a      (flag_a)
    );

endmodule

// File: hdl/instr_sequencer.sv
`timescale 1ns/1ps

module instr_sequencer
    import cpu_pkg::*;
(
    input  logic     clock,
    input  logic     arst_n,
    input  word_t    mem_rdata,
    input  word_t    operand_a,
    input  word_t    store_addr,
    input  logic     branch_taken,
    input  word_t    branch_target,
    output opcode_t  opcode,
    output reg_sel_t dst_sel,
    output reg_sel_t src_a_sel,
    output reg_sel_t src_b_sel,
    output imm_t     imm,
    output logic     exec,
    output word_t    mem_addr,
    output word_t    mem_wdata,
    output logic     mem_read,
    output logic     mem_write,
    output logic     halted
);

    // stop parks the core after a halt.
    typedef enum logic [1:0] {
        PH_STOP,
        PH_FETCH,
        PH_DECODE,
        PH_EXEC
    } phase_t;

    phase_t phase;
    word_t  pc;
    word_t  instr;
    logic   is_store;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase  <= PH_FETCH;
            pc     <= '0;
            halted <= 1'b0;
        end
        else
        begin
            case (phase)
                PH_FETCH:  phase <= PH_DECODE;
                PH_DECODE: phase <= PH_EXEC;
                PH_EXEC:
                begin
                    pc <= branch_taken ? branch_target : pc + word_t'(1);
                    if (opcode == OP_HALT)
                    begin
                        halted <= 1'b1;
                        phase  <= PH_STOP;
                    end
                    else
                        phase <= PH_FETCH;
                end
                // stop holds the core until the next reset.
                default: phase <= PH_STOP;
            endcase
        end
    end

    // read data arrives one cycle after the fetch strobe.
    always_ff @(posedge clock)
    begin
        if (phase == PH_DECODE)
            instr <= mem_rdata;
    end

    assign opcode    = opcode_t'(instr[OPC_MSB:OPC_LSB]);
    assign dst_sel   = instr[DST_MSB:DST_LSB];
    assign src_a_sel = instr[SRC_A_MSB:SRC_A_LSB];
    assign src_b_sel = instr[SRC_B_MSB:SRC_B_LSB];
    assign imm       = instr[IMM_MSB:IMM_LSB];

    assign exec     = (phase == PH_EXEC);
    assign is_store = exec && (opcode == OP_STORE);

    // no fetch while reset is held.
    assign mem_read  = arst_n && (phase == PH_FETCH);
    assign mem_write = is_store;
    assign mem_addr  = is_store ? store_addr : pc;
    assign mem_wdata = is_store ? operand_a : '0;

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import cpu_pkg::*;
(
    input  logic     exec,
    input  opcode_t  opcode,
    input  reg_sel_t dst_sel,
    input  imm_t     imm,
    input  word_t    operand_a,
    input  word_t    operand_b,
    input  logic     flag_a,
    output logic     wr_en,
    output logic     wr_word_en,
    output logic     wr_flag,
    output reg_sel_t wr_sel,
    output word_t    wr_word,
    output logic     branch_taken,
    output word_t    branch_target
);

    logic [WORD_W:0] wide_result;
    word_t           result;
    logic            result_flag;
    logic            writes_reg;
    logic            writes_word;

    always_comb
    begin
        wide_result = '0;
        result      = '0;
        result_flag = 1'b0;
        writes_reg  = 1'b1;
        writes_word = 1'b1;
        case (opcode)
            OP_ADD:
            begin
                // top bit is the carry out.
                wide_result = {1'b0, operand_a} + {1'b0, operand_b};
                result      = wide_result[WORD_W-1:0];
                result_flag = wide_result[WORD_W];
            end
            OP_SUB:
            begin
                // top bit is set when b exceeds a.
                wide_result = {1'b0, operand_a} - {1'b0, operand_b};
                result      = wide_result[WORD_W-1:0];
                result_flag = wide_result[WORD_W];
            end
            OP_AND: result = operand_a & operand_b;
            OP_OR:  result = operand_a | operand_b;
            OP_XOR: result = operand_a ^ operand_b;
            OP_LDL: result = {{(WORD_W-IMM_W){1'b0}}, imm};
            // source a names the destination so its low half survives.
            OP_LDH: result = {imm, operand_a[IMM_W-1:0]};
            OP_CMP:
            begin
                result_flag = (operand_a < operand_b);
                writes_word = 1'b0;
            end
            default:
            begin
                writes_reg  = 1'b0;
                writes_word = 1'b0;
            end
        endcase
    end

    assign wr_en      = exec && writes_reg;
    assign wr_word_en = writes_word;
    assign wr_flag    = result_flag;
    assign wr_sel     = dst_sel;
    assign wr_word    = result;

    assign branch_taken  = exec && (opcode == OP_BRANCH) && flag_a;
    assign branch_target = {{(WORD_W-IMM_W){1'b0}}, imm};

endmodule

// File: hdl/operand_select.sv
`timescale 1ns/1ps

module operand_select
    import cpu_pkg::*;
(
    input  word_t                slice_words [NUM_REGS],
    input  logic  [NUM_REGS-1:0] slice_flags,
    input  reg_sel_t             src_a_sel,
    input  reg_sel_t             src_b_sel,
    output word_t                operand_a,
    output word_t                operand_b,
    output word_t                store_addr,
    output logic                 flag_a
);

    always_comb
    begin
        operand_a = '0;
        operand_b = '0;
        flag_a    = 1'b0;
        for (int i = 0; i < NUM_REGS; i++)
        begin
            if (src_a_sel == reg_sel_t'(i))
            begin
                operand_a = slice_words[i];
                flag_a    = slice_flags[i];
            end
            if (src_b_sel == reg_sel_t'(i))
                operand_b = slice_words[i];
        end
    end

    // stores always address through h.
    assign store_addr = slice_words[STORE_ADDR_REG];

endmodule

// File: hdl/reg_slice.sv
`timescale 1ns/1ps

module reg_slice
    import cpu_pkg::*;
#(
    parameter int slice_index = 0
)(
    input  logic     clock,
    input  logic     arst_n,
    input  logic     wr_en,
    input  logic     wr_word_en,
    input  logic     wr_flag,
    input  reg_sel_t wr_sel,
    input  word_t    wr_word,
    output word_t    word,
    output logic     flag
);

    logic selected;

    assign selected = wr_en && (wr_sel == reg_sel_t'(slice_index));

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            word <= '0;
            flag <= 1'b0;
        end
        else if (selected)
        begin
            // compare leaves the word alone.
            if (wr_word_en)
                word <= wr_word;
            flag <= wr_flag;
        end
    end

endmodule

// File: hdl/cpu_pkg.sv
package cpu_pkg;

    // core widths.
    localparam int WORD_W = 32;
    localparam int IMM_W = 16;
    localparam int SEL_W = 3;
    localparam int OPC_W = 7;

    localparam int NUM_REGS = 8;
    // register h addresses every store.
    localparam int STORE_ADDR_REG = 7;

    // instruction field positions.
    localparam int OPC_LSB = 0;
    localparam int OPC_MSB = 6;
    localparam int DST_LSB = 7;
    localparam int DST_MSB = 9;
    localparam int SRC_A_LSB = 10;
    localparam int SRC_A_MSB = 12;
    localparam int SRC_B_LSB = 13;
    localparam int SRC_B_MSB = 15;
    localparam int IMM_LSB = 16;
    localparam int IMM_MSB = 31;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [IMM_W-1:0] imm_t;
    typedef logic [SEL_W-1:0] reg_sel_t;

    // unlisted encodings run as nop.
    typedef enum logic [OPC_W-1:0] {
        OP_NOP    = 7'd0,
        OP_ADD    = 7'd1,
        OP_SUB    = 7'd2,
        OP_AND    = 7'd3,
        OP_OR     = 7'd4,
        OP_XOR    = 7'd5,
        OP_LDL    = 7'd6,
        OP_STORE  = 7'd7,
        OP_LDH    = 7'd8,
        OP_CMP    = 7'd9,
        OP_BRANCH = 7'd10,
        OP_HALT   = 7'd11
    } opcode_t;

endpackage
